// ==== ctrlPkg.sv ====
// Shared field types, FSM and select enums, and the packed structs
// for the decoded instruction and the datapath control word
`default_nettype none

package ctrlPkg;

	// Instruction fields
	typedef logic [1:0] opClass_t;  // Operation class
	typedef logic [2:0] cmd_t;      // Command within class
	typedef logic [3:0] aluFlags_t; // ALU status flags

	// Flag positions inside aluFlags_t
	localparam int FLAG_ZERO  = 2;
	localparam int FLAG_CARRY = 1;

	// Controller FSM states
	typedef enum logic [2:0] {
		IDLE   = 3'd0,
		FETCH  = 3'd1,
		DECODE = 3'd2,
		EXEC1  = 3'd3,
		EXEC2  = 3'd4,
		EXEC3  = 3'd5
	} ctrlState_t;

	// Instruction classes after decode
	typedef enum logic [3:0] {
		CL_ALU,     // Register or immediate data processing
		CL_ALU_IND, // ADD/SUB with memory operand
		CL_CLR,
		CL_SHIFT,
		CL_LDR,
		CL_STR,
		CL_MOV,
		CL_BUN,
		CL_BCOND,   // BEQ, BNE, BCS, BCC
		CL_END,
		CL_NOP      // Undefined encodings
	} instrClass_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_ORR = 3'd3,
		ALU_XOR = 3'd4
	} aluOp_t;

	typedef enum logic [2:0] {
		SH_RTL  = 3'd0,
		SH_RTR  = 3'd1,
		SH_SHL  = 3'd2,
		SH_ASHR = 3'd3,
		SH_LSHR = 3'd4
	} shiftOp_t;

	typedef enum logic [1:0] {PC_HOLD = 2'b00, PC_NEXT = 2'b01, PC_BRANCH = 2'b10} pcSrc_t;
	typedef enum logic [1:0] {ADR_PC = 2'b00, ADR_ALU = 2'b01, ADR_REG = 2'b10} adrSrc_t;
	typedef enum logic [1:0] {RES_ALU = 2'b00, RES_ZERO = 2'b10, RES_SHIFT = 2'b11} resultSrc_t;
	typedef enum logic [1:0] {A_PC = 2'b00, A_REG = 2'b01, A_MEM = 2'b10} aluSrcA_t;
	typedef enum logic [1:0] {B_REG = 2'b00, B_IMM = 2'b01, B_MEM = 2'b11} aluSrcB_t;
	typedef enum logic [1:0] {WD_RESULT = 2'b00, WD_MEM = 2'b01, WD_IMM = 2'b11} wd3Src_t;

	// Decoded instruction, held for the whole instruction
	typedef struct packed {
		instrClass_t instrClass;
		aluOp_t      aluOp;
		shiftOp_t    shiftOp;
		logic        useImm;    // ALU B operand from immediate field
		cmd_t        branchCmd; // Condition code, zero for non-branches
	} instrInfo_t;

	// Datapath controls
	typedef struct packed {
		logic       pcReset;
		logic       irWrite;
		logic       pcWrite;
		logic       regWrite;
		logic       memWrite;
		logic       regSrc;     // Shift source register select
		pcSrc_t     pcSrc;
		adrSrc_t    adrSrc;
		resultSrc_t resultSrc;
		aluSrcA_t   aluSrcA;
		aluSrcB_t   aluSrcB;
		aluOp_t     aluControl;
		shiftOp_t   shiftType;
		wd3Src_t    wd3Sel;
	} ctrlWord_t;

endpackage

`default_nettype wire

// ==== instrClassify.sv ====
// Instruction classifier
// Maps op, cmd and the immediate bit onto a class and its operand fields
`timescale 1ns/1ps
`default_nettype none

module instrClassify
	import ctrlPkg::*;
(
	input  opClass_t   op,
	input  cmd_t       cmd,
	input  logic       immediate,
	output instrInfo_t info
);

	always_comb
	begin
		info.instrClass = CL_NOP;
		info.aluOp      = ALU_ADD;  // Address add for memory ops
		info.shiftOp    = SH_RTL;
		info.useImm     = 1'b0;
		info.branchCmd  = '0;

		unique case (op)
			2'b00:  // Data processing
			begin
				unique case (cmd)
					3'b001, 3'b011: info.instrClass = CL_ALU_IND;
					3'b111:         info.instrClass = CL_CLR;
					default:        info.instrClass = CL_ALU;
				endcase
				// Opcode to ALU function
				unique case (cmd)
					3'b000, 3'b001: info.aluOp = ALU_ADD;
					3'b010, 3'b011: info.aluOp = ALU_SUB;
					3'b100:         info.aluOp = ALU_AND;
					3'b101:         info.aluOp = ALU_ORR;
					3'b110:         info.aluOp = ALU_XOR;
					default:        info.aluOp = ALU_ADD; // CLR, result forced to zero
				endcase
				info.useImm = immediate && (info.instrClass == CL_ALU);
			end
			2'b01:  // Shifts
			begin
				if (cmd <= 3'd4)
				begin
					info.instrClass = CL_SHIFT;
					info.shiftOp    = shiftOp_t'(cmd); // Encoding matches cmd
				end
			end
			2'b11:  // Memory and END
			begin
				unique case (cmd)
					3'b000:
					begin
						info.instrClass = CL_LDR;
						info.useImm     = 1'b1; // Base plus offset
					end
					3'b001: info.instrClass = CL_MOV;
					3'b010:
					begin
						info.instrClass = CL_STR;
						info.useImm     = 1'b1;
					end
					3'b111:
					begin
						if (immediate)
							info.instrClass = CL_END;
					end
					default: info.instrClass = CL_NOP;
				endcase
			end
			2'b10:  // Branches
			begin
				if (cmd == 3'b000)
					info.instrClass = CL_BUN;
				else if (cmd[2])
				begin
					info.instrClass = CL_BCOND;
					info.branchCmd  = cmd; // BEQ, BNE, BCS, BCC
				end
			end
			default: info.instrClass = CL_NOP;
		endcase
	end

endmodule

`default_nettype wire

// ==== controlSequencer.sv ====
// Controller FSM
// State register, next-state logic and conditional branch test
`timescale 1ns/1ps
`default_nettype none

module controlSequencer
	import ctrlPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       run,
	input  instrInfo_t info,
	input  aluFlags_t  aluFlags,
	output ctrlState_t state
);

	ctrlState_t nextState;
	logic       branchTaken;

	// Condition test on current flags
	always_comb
	begin
		unique case (info.branchCmd)
			3'b100:  branchTaken = aluFlags[FLAG_ZERO];    // BEQ
			3'b101:  branchTaken = !aluFlags[FLAG_ZERO];   // BNE
			3'b110:  branchTaken = aluFlags[FLAG_CARRY];   // BCS
			3'b111:  branchTaken = !aluFlags[FLAG_CARRY];  // BCC
			default: branchTaken = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		unique case (state)
			IDLE:
				nextState = run ? FETCH : IDLE; // Level sensitive start
			FETCH:
				nextState = DECODE;
			DECODE:
			begin
				unique case (info.instrClass)
					CL_END:          nextState = IDLE;
					CL_BUN, CL_NOP:  nextState = FETCH; // BUN writes PC here
					CL_BCOND:        nextState = branchTaken ? EXEC1 : FETCH;
					default:         nextState = EXEC1;
				endcase
			end
			EXEC1:
			begin
				unique case (info.instrClass)
					CL_SHIFT, CL_MOV, CL_BCOND: nextState = FETCH;
					default:                    nextState = EXEC2;
				endcase
			end
			EXEC2:
			begin
				// Memory operand needs one more cycle
				if (info.instrClass inside {CL_ALU_IND, CL_LDR})
					nextState = EXEC3;
				else
					nextState = FETCH;
			end
			EXEC3:
				nextState = FETCH;
			default:
				nextState = IDLE; // Recover from illegal encodings
		endcase
	end

	// Third execute cycle only after EXEC2 of a memory-operand instruction
	assertExec3Entry: assert property (@(posedge clk) disable iff (reset)
		(state == EXEC3) |-> ($past(state) == EXEC2) &&
			(info.instrClass inside {CL_ALU_IND, CL_LDR}))
		else $error("EXEC3 entered for class %s", info.instrClass.name());

	assertStateRange: assert property (@(posedge clk) disable iff (reset)
		state inside {IDLE, FETCH, DECODE, EXEC1, EXEC2, EXEC3})
		else $error("State out of range: %0d", state);

endmodule

`default_nettype wire

// ==== controlDecode.sv ====
// Control word generation
// Datapath controls per FSM state and instruction class
`timescale 1ns/1ps
`default_nettype none

module controlDecode
	import ctrlPkg::*;
(
	input  ctrlState_t state,
	input  instrInfo_t info,
	input  logic       immediate,
	output ctrlWord_t  ctrl
);

	always_comb
	begin
		ctrl = '0;  // All strobes low, first select values

		unique case (state)
			IDLE:
				ctrl.pcReset = 1'b1;  // PC back to first instruction
			FETCH:
			begin
				ctrl.irWrite = 1'b1;
				ctrl.pcWrite = 1'b1;
				ctrl.pcSrc   = PC_NEXT;
				ctrl.adrSrc  = ADR_PC;
			end
			DECODE:
			begin
				ctrl.regSrc = (info.instrClass == CL_SHIFT); // Shift reads the Rd port
				if (info.instrClass == CL_BUN)
				begin
					ctrl.pcWrite = 1'b1;
					ctrl.pcSrc   = PC_BRANCH;
				end
			end
			EXEC1:
			begin
				unique case (info.instrClass)
					CL_ALU:
					begin
						ctrl.aluSrcA    = A_REG;
						ctrl.aluSrcB    = immediate ? B_IMM : B_REG;
						ctrl.aluControl = info.aluOp;
					end
					CL_LDR, CL_STR:
					begin
						// Effective address
						ctrl.aluSrcA    = A_REG;
						ctrl.aluSrcB    = info.useImm ? B_IMM : B_REG;
						ctrl.aluControl = ALU_ADD;
					end
					CL_SHIFT:
					begin
						ctrl.regWrite  = 1'b1;
						ctrl.resultSrc = RES_SHIFT;
						ctrl.shiftType = info.shiftOp;
					end
					CL_MOV:
					begin
						ctrl.regWrite = 1'b1;
						ctrl.wd3Sel   = WD_IMM;  // Immediate straight to Rd
					end
					CL_BCOND:
					begin
						// Only taken branches get here
						ctrl.pcWrite = 1'b1;
						ctrl.pcSrc   = PC_BRANCH;
					end
					default: ;
				endcase
			end
			EXEC2:
			begin
				unique case (info.instrClass)
					CL_ALU:
					begin
						ctrl.regWrite  = 1'b1;
						ctrl.resultSrc = RES_ALU;
					end
					CL_CLR:
					begin
						ctrl.regWrite  = 1'b1;
						ctrl.resultSrc = RES_ZERO;  // Zero through result mux
					end
					CL_ALU_IND:
						ctrl.adrSrc = ADR_REG;  // Operand address from Rm
					CL_LDR:
						ctrl.adrSrc = ADR_ALU;
					CL_STR:
					begin
						ctrl.adrSrc   = ADR_ALU;
						ctrl.memWrite = 1'b1;
					end
					default: ;
				endcase
			end
			EXEC3:
			begin
				unique case (info.instrClass)
					CL_ALU_IND:
					begin
						ctrl.aluSrcA    = A_MEM;
						ctrl.aluSrcB    = B_MEM;
						ctrl.aluControl = info.aluOp;
						ctrl.regWrite   = 1'b1;
						ctrl.resultSrc  = RES_ALU;
					end
					CL_LDR:
					begin
						ctrl.regWrite = 1'b1;
						ctrl.wd3Sel   = WD_MEM;  // Loaded data to Rd
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	// Checked only once the state register holds a known value
	always_comb
	begin
		if (!$isunknown(state))
		begin
			assertWriteExclusive: assert (!(ctrl.regWrite && ctrl.memWrite))
				else $error("regWrite and memWrite both high in %s", state.name());
			assertPcResetIdle: assert (ctrl.pcReset == (state == IDLE))
				else $error("pcReset wrong in state %s", state.name());
		end
	end

endmodule

`default_nettype wire

// ==== controllerUnit.sv ====
// Controller top level
// Classifier, FSM and control word decode
`timescale 1ns/1ps
`default_nettype none

module controllerUnit
	import ctrlPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       run,
	input  opClass_t   op,
	input  cmd_t       cmd,
	input  logic       immediate,
	input  aluFlags_t  aluFlags,
	output ctrlState_t state,
	output ctrlWord_t  ctrl
);

	instrInfo_t info;  // Decoded instruction, shared by FSM and decode

	instrClassify classify (
		.op        (op),
		.cmd       (cmd),
		.immediate (immediate),
		.info      (info)
	);

	controlSequencer sequencer (
		.clk      (clk),
		.reset    (reset),
		.run      (run),
		.info     (info),
		.aluFlags (aluFlags),
		.state    (state)
	);

	controlDecode decode (
		.state     (state),
		.info      (info),
		.immediate (immediate),
		.ctrl      (ctrl)
	);

endmodule

`default_nettype wire

// ==== tbClock.sv ====
// Testbench clock source
// Free-running clock, 100 ns period, starts low
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic clk
);

	localparam int HALF_PERIOD = 50; // ns

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== tbControllerUnit.sv ====
// Controller testbench
// Random instruction stream, expected-state model, concurrent checks, timeout
`timescale 1ns/1ps
`default_nettype none

module tbControllerUnit
	import ctrlPkg::*;
();

	localparam int NUM_INSTR      = 400;
	localparam int RESET_CYCLES   = 10;
	localparam int TIMEOUT_CYCLES = NUM_INSTR * 5 + RESET_CYCLES + 50; // 5 = longest instruction
	localparam int SEED           = 32'h3427df94;
	localparam int DRIVE_DELAY    = 5;  // ns after rising edge
	localparam logic [$bits(ctrlWord_t)-1:0] IDLE_CTRL =
		{1'b1, {($bits(ctrlWord_t) - 1){1'b0}}}; // pcReset only

	logic       clk;
	logic       reset;
	logic       run;
	opClass_t   op;
	cmd_t       cmd;
	logic       immediate;
	aluFlags_t  aluFlags;
	ctrlState_t state;
	ctrlWord_t  ctrl;

	// Reference model
	instrClass_t curClass;
	aluOp_t      curAluOp;
	logic        curTaken;
	logic        modelValid;  // Set at first reset edge
	logic        modelIdle;
	int          phase;       // Cycles since FETCH
	ctrlState_t  expState;
	logic        expPcWrite;
	logic        expRegWrite;
	logic        expMemWrite;
	logic        aluStep;     // States where ALU does the instruction's own op
	wd3Src_t     expWd3;
	resultSrc_t  expResult;
	int          cycleCount = 0;

	tbClock clockGen (.clk(clk));

	controllerUnit uut (
		.clk       (clk),
		.reset     (reset),
		.run       (run),
		.op        (op),
		.cmd       (cmd),
		.immediate (immediate),
		.aluFlags  (aluFlags),
		.state     (state),
		.ctrl      (ctrl)
	);

	// Class from op/cmd table
	function automatic instrClass_t expectClass(input opClass_t o, input cmd_t c, input logic i);
		case ({o, c})
			5'b00001, 5'b00011: return CL_ALU_IND;
			5'b00111: return CL_CLR;
			5'b00000, 5'b00010, 5'b00100, 5'b00101, 5'b00110: return CL_ALU;
			5'b01000, 5'b01001, 5'b01010, 5'b01011, 5'b01100: return CL_SHIFT;
			5'b10000: return CL_BUN;
			5'b10100, 5'b10101, 5'b10110, 5'b10111: return CL_BCOND;
			5'b11000: return CL_LDR;
			5'b11001: return CL_MOV;
			5'b11010: return CL_STR;
			5'b11111: return i ? CL_END : CL_NOP;
			default: return CL_NOP;
		endcase
	endfunction

	function automatic aluOp_t expectAluOp(input cmd_t c);
		case (c)
			3'd0, 3'd1: return ALU_ADD;
			3'd2, 3'd3: return ALU_SUB;
			3'd4: return ALU_AND;
			3'd5: return ALU_ORR;
			3'd6: return ALU_XOR;
			default: return ALU_ADD;
		endcase
	endfunction

	// Zero flag is bit 2, carry bit 1
	function automatic logic branchTaken(input cmd_t c, input aluFlags_t f);
		case (c)
			3'b100: return f[2];   // BEQ
			3'b101: return !f[2];  // BNE
			3'b110: return f[1];   // BCS
			3'b111: return !f[1];  // BCC
			default: return 1'b0;
		endcase
	endfunction

	// Cycles from FETCH to next FETCH
	function automatic int instrLength(input instrClass_t cls, input logic taken);
		case (cls)
			CL_ALU, CL_CLR, CL_STR: return 4;
			CL_ALU_IND, CL_LDR:     return 5;
			CL_SHIFT, CL_MOV:       return 3;
			CL_BCOND:               return taken ? 3 : 2;
			default:                return 2;
		endcase
	endfunction

	assign curClass = expectClass(op, cmd, immediate);
	assign curAluOp = expectAluOp(cmd);
	assign curTaken = branchTaken(cmd, aluFlags);

	always @(posedge clk)
	begin
		if (reset)
		begin
			modelValid <= 1'b1;
			modelIdle  <= 1'b1;
			phase      <= 0;
		end
		else if (modelIdle)
		begin
			if (run)
			begin
				modelIdle <= 1'b0;  // FETCH next
				phase     <= 0;
			end
		end
		else if (phase == 1 && curClass == CL_END)
			modelIdle <= 1'b1;  // Straight back after DECODE
		else if (phase + 1 == instrLength(curClass, curTaken))
			phase <= 0;
		else
			phase <= phase + 1;
	end

	always_comb
	begin
		if (modelIdle)
			expState = IDLE;
		else
			case (phase)
				0:       expState = FETCH;
				1:       expState = DECODE;
				2:       expState = EXEC1;
				3:       expState = EXEC2;
				default: expState = EXEC3;
			endcase
		expPcWrite = (expState == FETCH) ||
			(expState == DECODE && curClass == CL_BUN) ||
			(expState == EXEC1 && curClass == CL_BCOND);  // Reached only if taken
		expRegWrite = (expState == EXEC1 && curClass inside {CL_SHIFT, CL_MOV}) ||
			(expState == EXEC2 && curClass inside {CL_ALU, CL_CLR}) ||
			(expState == EXEC3 && curClass inside {CL_ALU_IND, CL_LDR});
		expMemWrite = (expState == EXEC2 && curClass == CL_STR);
		aluStep = (expState == EXEC1 && curClass == CL_ALU) ||
			(expState == EXEC3 && curClass == CL_ALU_IND);
		expWd3 = WD_RESULT;
		if (curClass == CL_MOV)
			expWd3 = WD_IMM;
		else if (curClass == CL_LDR)
			expWd3 = WD_MEM;
		expResult = RES_ALU;
		if (curClass == CL_SHIFT)
			expResult = RES_SHIFT;
		else if (curClass == CL_CLR)
			expResult = RES_ZERO;
	end

	task automatic failRun();
		$display("sim failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic valueError(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		failRun();
	endtask

	// Polls 5 ns after each edge, inputs may change right after
	task automatic waitForState(input ctrlState_t target);
		do
		begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		while (state != target);
	endtask

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: END did not return the controller to IDLE in %0d cycles",
				TIMEOUT_CYCLES);
			failRun();
		end
	end

	checkState: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		state == expState) else valueError("state", 32'(state), 32'(expState));
	checkIdleWord: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		(expState == IDLE) |-> ctrl == IDLE_CTRL) else valueError("ctrl", 32'(ctrl), 32'(IDLE_CTRL));
	checkPcReset: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		ctrl.pcReset == (expState == IDLE))
		else valueError("pcReset", 32'(ctrl.pcReset), 32'(expState == IDLE));
	checkIrWrite: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		ctrl.irWrite == (expState == FETCH))
		else valueError("irWrite", 32'(ctrl.irWrite), 32'(expState == FETCH));
	checkPcWrite: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		ctrl.pcWrite == expPcWrite) else valueError("pcWrite", 32'(ctrl.pcWrite), 32'(expPcWrite));
	checkPcNext: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		(expState == FETCH) |-> ctrl.pcSrc == PC_NEXT)
		else valueError("pcSrc", 32'(ctrl.pcSrc), 32'(PC_NEXT));
	checkPcBranch: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		(expPcWrite && expState != FETCH) |-> ctrl.pcSrc == PC_BRANCH)
		else valueError("pcSrc", 32'(ctrl.pcSrc), 32'(PC_BRANCH));
	checkRegWrite: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		ctrl.regWrite == expRegWrite)
		else valueError("regWrite", 32'(ctrl.regWrite), 32'(expRegWrite));
	checkMemWrite: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		ctrl.memWrite == expMemWrite)
		else valueError("memWrite", 32'(ctrl.memWrite), 32'(expMemWrite));
	checkAluOp: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		aluStep |-> ctrl.aluControl == curAluOp)
		else valueError("aluControl", 32'(ctrl.aluControl), 32'(curAluOp));
	// Address add for loads and stores
	checkAddrAdd: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		(expState == EXEC1 && curClass inside {CL_LDR, CL_STR}) |-> ctrl.aluControl == ALU_ADD)
		else valueError("aluControl", 32'(ctrl.aluControl), 32'(ALU_ADD));
	checkAluSrcB: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		(expState == EXEC1 && curClass == CL_ALU) |-> ctrl.aluSrcB == (immediate ? B_IMM : B_REG))
		else valueError("aluSrcB", 32'(ctrl.aluSrcB), 32'(immediate ? B_IMM : B_REG));
	checkShiftType: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		(expState == EXEC1 && curClass == CL_SHIFT) |-> 32'(ctrl.shiftType) == 32'(cmd))
		else valueError("shiftType", 32'(ctrl.shiftType), 32'(cmd));
	checkWd3Sel: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		expRegWrite |-> ctrl.wd3Sel == expWd3)
		else valueError("wd3Sel", 32'(ctrl.wd3Sel), 32'(expWd3));
	checkResultSrc: assert property (@(posedge clk) disable iff (modelValid !== 1'b1)
		(expRegWrite && expWd3 == WD_RESULT) |-> ctrl.resultSrc == expResult)
		else valueError("resultSrc", 32'(ctrl.resultSrc), 32'(expResult));

	initial
	begin
		logic [31:0] rnd;
		int          n;

		reset     = 1'b1;
		run       = 1'b0;
		op        = '0;
		cmd       = '0;
		immediate = 1'b0;
		aluFlags  = '0;
		void'($urandom(SEED));

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY reset = 1'b0;
		repeat (3) @(posedge clk); // run low, must stay IDLE
		#DRIVE_DELAY run = 1'b1;

		for (n = 0; n < NUM_INSTR; n++)
		begin
			waitForState(FETCH);
			rnd       = $urandom;
			op        = rnd[1:0];
			cmd       = rnd[4:2];
			immediate = rnd[5];
			aluFlags  = rnd[9:6];
			if (op == 2'b11 && cmd == 3'b111)
				immediate = 1'b0;  // Undefined, END kept for last
		end

		// END, and drop run so IDLE holds
		waitForState(FETCH);
		op        = 2'b11;
		cmd       = 3'b111;
		immediate = 1'b1;
		run       = 1'b0;
		waitForState(IDLE);
		repeat (2) @(posedge clk);
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
ctrlPkg.sv
instrClassify.sv
controlSequencer.sv
controlDecode.sv
controllerUnit.sv
tbClock.sv
tbControllerUnit.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f tb.f --top-module tbControllerUnit -Mdir obj_dir -o simControllerUnit
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/simControllerUnit)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
